//--- bbc_mem_pkg.sv
package bbc_mem_pkg;

   // cpu side bus sizes
   localparam int CPU_ADR_W  = 16;
   localparam int ROMSEL_W   = 4;
   localparam int SLOT_OFS_W = 14;  // 16 KiB per paged slot

   // physical ram, main at the bottom, sideways banks from 64 KiB up
   localparam int RAM_ADR_W = 17;

   typedef logic [RAM_ADR_W-1:0] ram_adr_t;

   localparam ram_adr_t SWRAM_BASE = 17'h1_0000;

   // romsel[3:2] for the four sideways ram banks 4..7
   localparam logic [1:0] SWRAM_BANK_HI = 2'b01;

   // rom slot numbers for the two mappings in the menu
   localparam logic [ROMSEL_W-1:0] ROMSEL_BASIC_HI = 4'he;
   localparam logic [ROMSEL_W-1:0] ROMSEL_SMMC_HI  = 4'hc;
   localparam logic [ROMSEL_W-1:0] ROMSEL_BASIC_LO = 4'h0;
   localparam logic [ROMSEL_W-1:0] ROMSEL_SMMC_LO  = 4'h2;

   // rom store image numbers, as seen in loader addr[15:14]
   localparam int         ROM_IMG_CNT  = 3;
   localparam logic [1:0] ROM_SEL_OS    = 2'd0;
   localparam logic [1:0] ROM_SEL_BASIC = 2'd1;
   localparam logic [1:0] ROM_SEL_SMMC  = 2'd2;

   typedef struct packed {
      logic                 we;
      logic [CPU_ADR_W-1:0] adr;
      logic [ROMSEL_W-1:0]  romsel;
      logic [7:0]           wdata;
   } cpu_req_t;

   typedef enum logic [2:0] {
      REG_RAM,
      REG_OS,
      REG_BASIC,
      REG_SMMC,
      REG_SWRAM,
      REG_NONE
   } mem_region_e;

endpackage

//--- bbc_sys_pkg.sv
package bbc_sys_pkg;

   // loader address, top bit picks the rom store
   localparam int LOADER_ADR_W   = 18;
   localparam int LOADER_ROM_BIT = 17;

   typedef struct packed {
      logic [LOADER_ADR_W-1:0] addr;
      logic [7:0]              data;
   } loader_wr_t;

   // board and menu controls
   typedef struct packed {
      logic reset_req;    // menu reset entry
      logic rom_map_low;  // 1 = basic/smmc in slots 0 and 2
      logic pll_ready;    // pll lock
   } core_ctl_t;

endpackage

//--- bbc_reset_ctrl.sv
module bbc_reset_ctrl
   import bbc_sys_pkg::*;
#(
   parameter int REMAP_HOLD = 4095
) (
   input  logic      clk_32m,
   input  logic      arst_n,
   input  core_ctl_t ctl,
   input  logic      loader_active,
   output logic      core_reset
);

   localparam int CNT_W = (REMAP_HOLD > 1) ? $clog2(REMAP_HOLD + 1) : 1;

   logic             last_map;
   logic [CNT_W-1:0] hold_cnt;
   logic             map_chg;
   logic             hold_active;
   logic             reset_in;

   assign map_chg = ctl.rom_map_low != last_map;

   // the change cycle itself is the first held cycle
   assign hold_active = hold_cnt > CNT_W'(1);

   assign reset_in = !ctl.pll_ready
                  || ctl.reset_req
                  || loader_active
                  || map_chg
                  || hold_active;

   always_ff @(posedge clk_32m or negedge arst_n) begin
      if (!arst_n) begin
         last_map   <= 1'b0;
         hold_cnt   <= '0;
         core_reset <= 1'b1;
      end else begin
         last_map <= ctl.rom_map_low;
         if (map_chg) begin
            hold_cnt <= CNT_W'(REMAP_HOLD);  // restart window on every toggle
         end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
         end
         core_reset <= reset_in;
      end
   end

endmodule

//--- bbc_mem_map.sv
module bbc_mem_map
   import bbc_mem_pkg::*;
   import bbc_sys_pkg::*;
#(
   parameter int ROM_ADR_W = 14
) (
   input  logic                 clk_32m,
   input  logic                 arst_n,
   input  cpu_req_t             cpu_req,
   input  logic                 cpu_req_valid,
   input  logic                 loader_active,
   input  loader_wr_t           loader_wr,
   input  logic                 loader_wr_valid,
   input  logic                 rom_map_low,
   input  logic [7:0]           rom_os,
   input  logic [7:0]           rom_basic,
   input  logic [7:0]           rom_smmc,
   input  logic [7:0]           ram_rdata,
   output ram_adr_t             ram_adr,
   output logic                 ram_we,
   output logic [7:0]           ram_wdata,
   output logic [ROM_ADR_W-1:0] rom_adr,
   output logic                 rom_we,
   output logic [1:0]           rom_sel,
   output logic [7:0]           rom_wdata,
   output logic [7:0]           rd_data,
   output logic                 rd_valid
);

   mem_region_e region;
   mem_region_e rd_region_q;  // region of the read whose data arrives now
   logic        rd_pend_q;
   logic        basic_hit;
   logic        smmc_hit;
   logic        cpu_go;
   logic        cpu_ram_wr;
   logic        ld_go;
   ram_adr_t    cpu_ram_adr;
   logic [7:0]  sel_data;

   assign cpu_go = cpu_req_valid && !loader_active;
   assign ld_go  = loader_wr_valid && loader_active;

   assign basic_hit = rom_map_low ? (cpu_req.romsel == ROMSEL_BASIC_LO)
                                  : (cpu_req.romsel == ROMSEL_BASIC_HI);
   assign smmc_hit  = rom_map_low ? (cpu_req.romsel == ROMSEL_SMMC_LO)
                                  : (cpu_req.romsel == ROMSEL_SMMC_HI);

   always_comb begin
      region = REG_NONE;
      if (!cpu_req.adr[15]) begin
         region = REG_RAM;
      end else if (cpu_req.adr[14]) begin
         region = REG_OS;  // 0xc000 and up
      end else if (basic_hit) begin
         region = REG_BASIC;
      end else if (smmc_hit) begin
         region = REG_SMMC;
      end else if (cpu_req.romsel[3:2] == SWRAM_BANK_HI) begin
         region = REG_SWRAM;
      end
   end

   // bank n lands at 0x10000 + (n & 3) * 16 KiB
   assign cpu_ram_adr = (region == REG_SWRAM)
      ? (SWRAM_BASE | ram_adr_t'({cpu_req.romsel[1:0], cpu_req.adr[SLOT_OFS_W-1:0]}))
      : ram_adr_t'(cpu_req.adr);

   // rom regions and unmapped space swallow cpu writes
   assign cpu_ram_wr = cpu_go && cpu_req.we && (region == REG_RAM || region == REG_SWRAM);

   // loader takes over both memories while active
   assign ram_adr   = loader_active ? loader_wr.addr[RAM_ADR_W-1:0] : cpu_ram_adr;
   assign ram_wdata = loader_active ? loader_wr.data : cpu_req.wdata;
   assign ram_we    = loader_active ? (ld_go && !loader_wr.addr[LOADER_ROM_BIT]) : cpu_ram_wr;

   assign rom_adr   = loader_active ? loader_wr.addr[ROM_ADR_W-1:0]
                                    : cpu_req.adr[ROM_ADR_W-1:0];
   assign rom_we    = ld_go && loader_wr.addr[LOADER_ROM_BIT];
   assign rom_sel   = loader_wr.addr[15:14];
   assign rom_wdata = loader_wr.data;

   always_comb begin
      unique case (rd_region_q)
         REG_RAM, REG_SWRAM: sel_data = ram_rdata;
         REG_OS:             sel_data = rom_os;
         REG_BASIC:          sel_data = rom_basic;
         REG_SMMC:           sel_data = rom_smmc;
         default:            sel_data = 8'hff;  // floating bus
      endcase
   end

   always_ff @(posedge clk_32m or negedge arst_n) begin
      if (!arst_n) begin
         rd_pend_q <= 1'b0;
         rd_valid  <= 1'b0;
      end else begin
         rd_pend_q <= cpu_go && !cpu_req.we;
         rd_valid  <= rd_pend_q;
      end
   end

   always_ff @(posedge clk_32m) begin
      rd_region_q <= region;    // lines up with the memory output
      rd_data     <= sel_data;
   end

   a_no_cpu_during_load: assert property (
      @(posedge clk_32m) disable iff (!arst_n)
      loader_active |-> !cpu_req_valid
   );

endmodule

//--- bbc_rom_store.sv
module bbc_rom_store
   import bbc_mem_pkg::*;
#(
   parameter int ROM_ADR_W = 14
) (
   input  logic                 clk_32m,
   input  logic [ROM_ADR_W-1:0] adr,
   input  logic                 we,
   input  logic [1:0]           sel,
   input  logic [7:0]           wdata,
   output logic [7:0]           os,
   output logic [7:0]           basic,
   output logic [7:0]           smmc
);

   localparam int ROM_DEPTH = 2 ** ROM_ADR_W;

   // one array per image, all on the same address
   logic [7:0] img_mem [ROM_IMG_CNT][ROM_DEPTH];
   logic [7:0] img_q   [ROM_IMG_CNT];

   always_ff @(posedge clk_32m) begin
      for (int i = 0; i < ROM_IMG_CNT; i++) begin
         if (we && sel == 2'(i)) begin
            img_mem[i][adr] <= wdata;
         end
         img_q[i] <= img_mem[i][adr];  // all images read every cycle
      end
   end

   assign os    = img_q[ROM_SEL_OS];
   assign basic = img_q[ROM_SEL_BASIC];
   assign smmc  = img_q[ROM_SEL_SMMC];

   // loader must not aim at a fourth image
   a_sel_in_range: assert property (
      @(posedge clk_32m)
      we |-> sel <= ROM_SEL_SMMC
   );

endmodule

//--- bbc_main_ram.sv
module bbc_main_ram
   import bbc_mem_pkg::*;
(
   input  logic       clk_32m,
   input  ram_adr_t   adr,
   input  logic       we,
   input  logic [7:0] wdata,
   output logic [7:0] rdata
);

   localparam int RAM_DEPTH = 2 ** RAM_ADR_W;  // 128 KiB

   logic [7:0] mem [RAM_DEPTH];

   // stand-in for the sdram, one cycle read latency
   always_ff @(posedge clk_32m) begin
      if (we) begin
         mem[adr] <= wdata;
         rdata    <= wdata;  // write-first
      end else begin
         rdata <= mem[adr];
      end
   end

endmodule

//--- bbc_mem_top.sv
module bbc_mem_top
   import bbc_mem_pkg::*;
   import bbc_sys_pkg::*;
#(
   parameter int REMAP_HOLD = 4095,
   parameter int ROM_ADR_W  = 14
) (
   input  logic       clk_32m,
   input  logic       arst_n,
   input  cpu_req_t   cpu_req,
   input  logic       cpu_req_valid,
   input  logic       loader_active,
   input  loader_wr_t loader_wr,
   input  logic       loader_wr_valid,
   input  core_ctl_t  ctl,
   output logic [7:0] rd_data,
   output logic       rd_valid,
   output logic       core_reset
);

   ram_adr_t             ram_adr;
   logic                 ram_we;
   logic [7:0]           ram_wdata;
   logic [7:0]           ram_rdata;
   logic [ROM_ADR_W-1:0] rom_adr;
   logic                 rom_we;
   logic [1:0]           rom_sel;
   logic [7:0]           rom_wdata;
   logic [7:0]           rom_os;
   logic [7:0]           rom_basic;
   logic [7:0]           rom_smmc;

   bbc_reset_ctrl #(
      .REMAP_HOLD (REMAP_HOLD)
   ) i_reset_ctrl (
      .clk_32m       (clk_32m),
      .arst_n        (arst_n),
      .ctl           (ctl),
      .loader_active (loader_active),
      .core_reset    (core_reset)
   );

   bbc_mem_map #(
      .ROM_ADR_W (ROM_ADR_W)
   ) i_mem_map (
      .clk_32m         (clk_32m),
      .arst_n          (arst_n),
      .cpu_req         (cpu_req),
      .cpu_req_valid   (cpu_req_valid),
      .loader_active   (loader_active),
      .loader_wr       (loader_wr),
      .loader_wr_valid (loader_wr_valid),
      .rom_map_low     (ctl.rom_map_low),
      .rom_os          (rom_os),
      .rom_basic       (rom_basic),
      .rom_smmc        (rom_smmc),
      .ram_rdata       (ram_rdata),
      .ram_adr         (ram_adr),
      .ram_we          (ram_we),
      .ram_wdata       (ram_wdata),
      .rom_adr         (rom_adr),
      .rom_we          (rom_we),
      .rom_sel         (rom_sel),
      .rom_wdata       (rom_wdata),
      .rd_data         (rd_data),
      .rd_valid        (rd_valid)
   );

   bbc_rom_store #(
      .ROM_ADR_W (ROM_ADR_W)
   ) i_rom_store (
      .clk_32m (clk_32m),
      .adr     (rom_adr),
      .we      (rom_we),
      .sel     (rom_sel),
      .wdata   (rom_wdata),
      .os      (rom_os),
      .basic   (rom_basic),
      .smmc    (rom_smmc)
   );

   bbc_main_ram i_main_ram (
      .clk_32m (clk_32m),
      .adr     (ram_adr),
      .we      (ram_we),
      .wdata   (ram_wdata),
      .rdata   (ram_rdata)
   );

endmodule

//--- tb_bbc_mem.sv
module tb_bbc_mem
   import bbc_mem_pkg::*;
   import bbc_sys_pkg::*;
();

   localparam int HOLD = 20;

   logic       clk_32m = 1'b0;
   logic       arst_n;
   cpu_req_t   cpu_req;
   logic       cpu_req_valid;
   logic       loader_active;
   loader_wr_t loader_wr;
   logic       loader_wr_valid;
   core_ctl_t  ctl;
   logic [7:0] rd_data;
   logic       rd_valid;
   logic       core_reset;

   logic [7:0]  rsp_q [$];  // read data in arrival order
   logic [31:0] seed = 32'h84c3_c876;
   logic [7:0]  rom_ref [3][4];
   logic [13:0] rom_ofs [4] = '{14'h0000, 14'h0abc, 14'h2345, 14'h3fff};
   logic [15:0] main_adr [4] = '{16'h0000, 16'h1234, 16'h4321, 16'h7fff};
   logic [7:0]  main_ref [4];
   int          err_cnt = 0;
   int          chk_cnt = 0;
   int          test_cnt = 0;
   string       cur_test;

   always #2 clk_32m = ~clk_32m;

   bbc_mem_top #(
      .REMAP_HOLD (HOLD),
      .ROM_ADR_W  (14)
   ) i_dut (.*);

   always @(negedge clk_32m) begin
      if (rd_valid) rsp_q.push_back(rd_data);
   end

   function automatic logic [7:0] rand_byte();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed[23:16];
   endfunction

   task automatic check_value(input logic [7:0] exp, input logic [7:0] act);
      chk_cnt++;
      assert (act === exp) else begin
         $display("CHECK FAILED %s: expected %02h, actual %02h", cur_test, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_flag(input logic cond, input string what);
      chk_cnt++;
      assert (cond) else begin
         $display("ERROR in %s: %s", cur_test, what);
         err_cnt++;
      end
   endtask

   task automatic report_test(input int errs_before);
      test_cnt++;
      $display("test %s done, %0d errors", cur_test, err_cnt - errs_before);
   endtask

   task automatic cpu_access(input logic we, input logic [15:0] adr,
                             input logic [3:0] romsel, input logic [7:0] wdata);
      @(posedge clk_32m);
      cpu_req_valid  <= 1'b1;
      cpu_req.we     <= we;
      cpu_req.adr    <= adr;
      cpu_req.romsel <= romsel;
      cpu_req.wdata  <= wdata;
   endtask

   task automatic cpu_idle();
      @(posedge clk_32m);
      cpu_req_valid <= 1'b0;
   endtask

   task automatic wait_rsp(input int n, output int t);
      t = 0;
      while (rsp_q.size() < n && t < 50) begin
         @(posedge clk_32m);
         t++;
      end
      check_flag(rsp_q.size() >= n, "read data never arrived");
   endtask

   task automatic read_check(input logic [15:0] adr, input logic [3:0] romsel,
                             input logic [7:0] exp);
      int t;
      rsp_q.delete();
      cpu_access(1'b0, adr, romsel, 8'h00);
      cpu_idle();
      wait_rsp(1, t);
      check_flag(t == 2, "read did not complete two cycles after its strobe");
      if (rsp_q.size() > 0) check_value(exp, rsp_q.pop_front());
   endtask

   task automatic loader_write(input logic [17:0] addr, input logic [7:0] data);
      @(posedge clk_32m);
      loader_wr_valid <= 1'b1;
      loader_wr.addr  <= addr;
      loader_wr.data  <= data;
   endtask

   task automatic wait_core_reset(input logic level);
      int t;
      t = 0;
      do begin
         @(negedge clk_32m);
         t++;
      end while (core_reset !== level && t < 100);
      check_flag(core_reset === level, "core_reset stuck at the wrong level");
   endtask

   task automatic test_reset();
      int errs;
      errs = err_cnt;
      cur_test = "reset";
      repeat (8) begin
         @(negedge clk_32m);
         check_value(8'd0, {7'd0, rd_valid});
         check_value(8'd1, {7'd0, core_reset});
      end
      @(posedge clk_32m);
      arst_n <= 1'b1;
      @(negedge clk_32m);
      check_value(8'd0, {7'd0, rd_valid});
      check_value(8'd1, {7'd0, core_reset});  // still from the async reset
      wait_core_reset(1'b0);
      report_test(errs);
   endtask

   task automatic test_rom_load();
      int errs;
      logic [7:0] ram_byte;
      errs = err_cnt;
      cur_test = "rom_load";
      @(posedge clk_32m);
      loader_active <= 1'b1;
      for (int img = 0; img < 3; img++) begin
         for (int k = 0; k < 4; k++) begin
            rom_ref[img][k] = rand_byte();
            loader_write({1'b1, 1'b0, 2'(img), rom_ofs[k]}, rom_ref[img][k]);
            @(negedge clk_32m);
            check_value(8'd1, {7'd0, core_reset});
         end
      end
      ram_byte = rand_byte();
      loader_write(18'h0_0100, ram_byte);  // one byte into main ram
      @(posedge clk_32m);
      loader_wr_valid <= 1'b0;
      loader_active   <= 1'b0;
      wait_core_reset(1'b0);
      for (int k = 0; k < 4; k++) begin
         read_check(16'hc000 | 16'(rom_ofs[k]), 4'h0, rom_ref[0][k]);
         read_check(16'h8000 | 16'(rom_ofs[k]), 4'he, rom_ref[1][k]);
         read_check(16'h8000 | 16'(rom_ofs[k]), 4'hc, rom_ref[2][k]);
         read_check(16'h8000 | 16'(rom_ofs[k]), 4'h9, 8'hff);  // empty slot
      end
      read_check(16'h0100, 4'h0, ram_byte);
      report_test(errs);
   endtask

   task automatic test_ram();
      int errs;
      int t;
      logic [7:0] base;
      errs = err_cnt;
      cur_test = "ram";
      for (int k = 0; k < 4; k++) begin
         main_ref[k] = rand_byte();
         cpu_access(1'b1, main_adr[k], 4'h0, main_ref[k]);
      end
      cpu_idle();
      for (int k = 0; k < 4; k++) read_check(main_adr[k], 4'h0, main_ref[k]);
      // same offset in banks 4..7, each bank gets its own byte
      base = rand_byte();
      for (int b = 4; b < 8; b++) cpu_access(1'b1, 16'h8155, 4'(b), base + 8'(b));
      cpu_idle();
      for (int b = 4; b < 8; b++) read_check(16'h8155, 4'(b), base + 8'(b));
      cpu_access(1'b1, 16'h8000 | 16'(rom_ofs[1]), 4'he, ~rom_ref[1][1]);
      cpu_access(1'b1, 16'hc000 | 16'(rom_ofs[2]), 4'h0, ~rom_ref[0][2]);
      cpu_idle();
      read_check(16'h8000 | 16'(rom_ofs[1]), 4'he, rom_ref[1][1]);
      read_check(16'hc000 | 16'(rom_ofs[2]), 4'h0, rom_ref[0][2]);
      rsp_q.delete();
      for (int k = 0; k < 4; k++) cpu_access(1'b0, main_adr[k], 4'h0, 8'h00);
      cpu_idle();
      wait_rsp(4, t);
      for (int k = 0; k < 4 && rsp_q.size() > 0; k++) check_value(main_ref[k], rsp_q.pop_front());
      report_test(errs);
   endtask

   task automatic test_remap();
      int errs;
      int hi_cnt;
      int t;
      errs = err_cnt;
      cur_test = "remap";
      @(posedge clk_32m);
      ctl.rom_map_low <= 1'b1;
      hi_cnt = 0;
      t = 0;
      do begin
         @(negedge clk_32m);
         if (core_reset) hi_cnt++;
         t++;
      end while (!(hi_cnt > 0 && !core_reset) && t < 100);
      check_flag(hi_cnt >= HOLD - 1 && hi_cnt <= HOLD + 1,
                 $sformatf("core_reset held for %0d cycles after remap", hi_cnt));
      for (int k = 0; k < 4; k++) begin
         read_check(16'h8000 | 16'(rom_ofs[k]), 4'h0, rom_ref[1][k]);
         read_check(16'h8000 | 16'(rom_ofs[k]), 4'h2, rom_ref[2][k]);
         read_check(16'h8000 | 16'(rom_ofs[k]), 4'he, 8'hff);
      end
      report_test(errs);
   endtask

   task automatic test_sources();
      int errs;
      errs = err_cnt;
      cur_test = "sources";
      @(posedge clk_32m);
      ctl.reset_req <= 1'b1;
      wait_core_reset(1'b1);
      @(posedge clk_32m);
      ctl.reset_req <= 1'b0;
      wait_core_reset(1'b0);
      @(posedge clk_32m);
      loader_active <= 1'b1;
      wait_core_reset(1'b1);
      @(posedge clk_32m);
      loader_active <= 1'b0;
      wait_core_reset(1'b0);
      @(posedge clk_32m);
      ctl.pll_ready <= 1'b0;  // pll loses lock
      wait_core_reset(1'b1);
      @(posedge clk_32m);
      ctl.pll_ready <= 1'b1;
      wait_core_reset(1'b0);
      report_test(errs);
   endtask

   initial begin
      arst_n          = 1'b0;
      cpu_req         = '0;
      cpu_req_valid   = 1'b0;
      loader_active   = 1'b0;
      loader_wr       = '0;
      loader_wr_valid = 1'b0;
      ctl.reset_req   = 1'b0;
      ctl.rom_map_low = 1'b0;
      ctl.pll_ready   = 1'b1;
      test_reset();
      test_rom_load();
      test_ram();
      test_remap();
      test_sources();
      $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

//--- list.f
bbc_mem_pkg.sv
bbc_sys_pkg.sv
bbc_reset_ctrl.sv
bbc_mem_map.sv
bbc_rom_store.sv
bbc_main_ram.sv
bbc_mem_top.sv
tb_bbc_mem.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_bbc_mem -f list.f
out=$(./obj_dir/Vtb_bbc_mem)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "Simulation PASSED"; then
   exit 0
fi
exit 1
